/* files.f */
src/vid_ctrl_pkg.sv
src/pps_gen.sv
src/clk_counter.sv
src/frame_rate.sv
src/vid_regs.sv
src/vid_ctrl_top.sv
sim/vid_ctrl_sva.sv
sim/vid_ctrl_tb.sv

/* Bender.yml */
package:
  name: vid_ctrl

sources:
  - src/vid_ctrl_pkg.sv
  - src/pps_gen.sv
  - src/clk_counter.sv
  - src/frame_rate.sv
  - src/vid_regs.sv
  - src/vid_ctrl_top.sv
  - target: simulation
    files:
      - sim/vid_ctrl_sva.sv
      - sim/vid_ctrl_tb.sv

/* sim/vid_ctrl_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Video control testbench
// Drives the bus, the test clocks and the frame strobe, and checks every
// read and the configuration outputs against a shadow register model
////////////////////////////////////////////////////////////////////////////

module vid_ctrl_tb;

	localparam int WIN     = 300;
	localparam int LGDIM   = 12;
	localparam int SYS_PER = 8;
	// Test clock periods, Si, pixel and HDMI
	localparam int SI_PER  = 4;
	localparam int PX_PER  = 10;
	localparam int HD_PER  = 16;
	localparam int STB_DIV = 12;
	localparam logic [3:0] WR_ADRS [8] = '{4'h0, 4'h8, 4'h9, 4'hA, 4'hB, 4'h5, 4'hD, 4'hF};

	logic i_clk = 1'b0;
	logic i_si_clk = 1'b0;
	logic i_px_clk = 1'b0;
	logic i_hdmi_clk = 1'b0;
	logic pix_reset_sys, i_frame_stb, i_wb_cyc, i_wb_stb, i_wb_we;
	logic [3:0] i_wb_addr, i_wb_sel;
	logic [31:0] i_wb_data, o_wb_data;
	logic o_wb_ack, o_src_sel, o_vid_reset;
	logic [1:0] o_pxclk_sel, o_alpha;
	logic [2:0] o_cmap_mode;
	logic [LGDIM-1:0] o_hm_width, o_hm_porch, o_hm_synch, o_hm_raw;
	logic [LGDIM-1:0] o_vm_height, o_vm_porch, o_vm_synch, o_vm_raw;

	// Shadow registers
	vid_ctrl_pkg::ctl_word_u sh_ctl;
	logic                    sh_src_sel;
	logic [LGDIM-1:0]        sh_hm [4];
	logic [LGDIM-1:0]        sh_vm [4];
	// Strobe pattern, 0 off, 1 every STB_DIV cycles, 2 every cycle
	int                      stb_mode;
	int                      stb_div;
	logic [15:0]             lfsr;
	// Pending requests, in order
	string                   exp_name [$];
	logic [31:0]             exp_val [$];
	int                      exp_tol [$];
	bit                      exp_rd [$];
	int                      req_cyc [$];
	int                      ncyc;
	int                      n_checks;
	int                      val_errors;
	int                      other_errors;

	vid_ctrl_top #(.CLOCKFREQ_HZ(WIN), .LGDIM(LGDIM)) dut0 (.*);

	always #(SYS_PER / 2) i_clk = ~i_clk;
	always #(SI_PER / 2) i_si_clk = ~i_si_clk;
	always #(PX_PER / 2) i_px_clk = ~i_px_clk;
	always #(HD_PER / 2) i_hdmi_clk = ~i_hdmi_clk;

	// Frame strobe source
	always @(posedge i_clk) begin
		stb_div     <= (stb_div == STB_DIV - 1) ? 0 : stb_div + 1;
		i_frame_stb <= (stb_mode == 2) || (stb_mode == 1 && stb_div == 0);
	end

	////////////////////////////////////////////////////////////////////////////
	// Random data and reference model
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic apply_write(input logic [3:0] adr, input logic [31:0] data,
			input logic [3:0] sel);
		vid_ctrl_pkg::ctl_word_u w;
		w.word = data;
		if (adr == vid_ctrl_pkg::ADR_CONTROL) begin
			if (sel[0]) begin
				sh_ctl.ctl_fields.pxclk_sel = w.ctl_fields.pxclk_sel;
				sh_ctl.ctl_fields.vid_reset = w.ctl_fields.vid_reset;
				// Source only with both request and clock bit 1
				sh_src_sel = w.ctl_fields.src_req && w.ctl_fields.pxclk_sel[1];
			end
			if (sel[1]) begin
				sh_ctl.ctl_fields.cmap_mode = w.ctl_fields.cmap_mode;
				sh_ctl.ctl_fields.alpha     = w.ctl_fields.alpha;
			end
		end else if (adr >= vid_ctrl_pkg::ADR_SIZE && adr <= vid_ctrl_pkg::ADR_RAW) begin
			if (sel[1:0] == 2'b11)
				sh_hm[adr[1:0]] = w.mode_pair.horz[LGDIM-1:0];
			if (sel[3:2] == 2'b11)
				sh_vm[adr[1:0]] = w.mode_pair.vert[LGDIM-1:0];
		end
	endtask

	function automatic logic [31:0] expected_read(input logic [3:0] adr);
		vid_ctrl_pkg::ctl_word_u r;
		r.word = '0;
		case (adr)
			vid_ctrl_pkg::ADR_CONTROL: begin
				r.ctl_fields.alpha     = sh_ctl.ctl_fields.alpha;
				r.ctl_fields.cmap_mode = sh_ctl.ctl_fields.cmap_mode;
				r.ctl_fields.src_req   = sh_src_sel;
				r.ctl_fields.pxclk_sel = sh_ctl.ctl_fields.pxclk_sel;
				r.ctl_fields.vid_reset = sh_ctl.ctl_fields.vid_reset;
			end
			// Edges of each test clock in one window
			vid_ctrl_pkg::ADR_SIFREQ:   r.word = 32'(WIN * SYS_PER / SI_PER);
			vid_ctrl_pkg::ADR_PXFREQ:   r.word = 32'(WIN * SYS_PER / PX_PER);
			vid_ctrl_pkg::ADR_HDMIFREQ: r.word = 32'(WIN * SYS_PER / HD_PER);
			vid_ctrl_pkg::ADR_SIZE, vid_ctrl_pkg::ADR_PORCH,
			vid_ctrl_pkg::ADR_SYNC, vid_ctrl_pkg::ADR_RAW: begin
				r.mode_pair.horz = 16'(sh_hm[adr[1:0]]);
				r.mode_pair.vert = 16'(sh_vm[adr[1:0]]);
			end
			vid_ctrl_pkg::ADR_FPS: begin
				if (!sh_ctl.ctl_fields.vid_reset && stb_mode == 2)
					r.word = 32'd255;
				else if (!sh_ctl.ctl_fields.vid_reset && stb_mode == 1)
					r.word = 32'(WIN / STB_DIV);
			end
			default: r.word = '0;
		endcase
		return r.word;
	endfunction

	// Slack from synchronisers and strobe phase
	function automatic int read_tolerance(input logic [3:0] adr);
		if (adr >= vid_ctrl_pkg::ADR_SIFREQ && adr <= vid_ctrl_pkg::ADR_HDMIFREQ)
			return 2;
		if (adr == vid_ctrl_pkg::ADR_FPS && stb_mode == 1)
			return 1;
		return 0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expv,
			input logic [31:0] act, input int tol);
		int diff;
		bit ok;
		diff = int'(act) - int'(expv);
		ok   = (tol == 0) ? (act === expv) :
			(!$isunknown(act) && diff <= tol && diff >= -tol);
		n_checks++;
		assert (ok) else begin
			val_errors++;
			$display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expv, act);
		end
	endtask

	task automatic check_outputs(input string name);
		check_value({name, " pxclk_sel"}, 32'(sh_ctl.ctl_fields.pxclk_sel), 32'(o_pxclk_sel), 0);
		check_value({name, " src_sel"}, 32'(sh_src_sel), 32'(o_src_sel), 0);
		check_value({name, " cmap_mode"}, 32'(sh_ctl.ctl_fields.cmap_mode), 32'(o_cmap_mode), 0);
		check_value({name, " alpha"}, 32'(sh_ctl.ctl_fields.alpha), 32'(o_alpha), 0);
		check_value({name, " vid_reset"}, 32'(sh_ctl.ctl_fields.vid_reset), 32'(o_vid_reset), 0);
		check_value({name, " hm_width"}, 32'(sh_hm[0]), 32'(o_hm_width), 0);
		check_value({name, " hm_porch"}, 32'(sh_hm[1]), 32'(o_hm_porch), 0);
		check_value({name, " hm_synch"}, 32'(sh_hm[2]), 32'(o_hm_synch), 0);
		check_value({name, " hm_raw"}, 32'(sh_hm[3]), 32'(o_hm_raw), 0);
		check_value({name, " vm_height"}, 32'(sh_vm[0]), 32'(o_vm_height), 0);
		check_value({name, " vm_porch"}, 32'(sh_vm[1]), 32'(o_vm_porch), 0);
		check_value({name, " vm_synch"}, 32'(sh_vm[2]), 32'(o_vm_synch), 0);
		check_value({name, " vm_raw"}, 32'(sh_vm[3]), 32'(o_vm_raw), 0);
	endtask

	// Sampled mid-cycle, ack due two cycles after its request
	always @(negedge i_clk) begin : compare_acks
		int lat;
		ncyc = ncyc + 1;
		if (o_wb_ack === 1'b1) begin
			assert (req_cyc.size() != 0 && exp_val.size() != 0) else begin
				other_errors++;
				$display("Bus ack seen with no request pending");
			end
			if (req_cyc.size() != 0 && exp_val.size() != 0) begin
				lat = ncyc - req_cyc.pop_front();
				assert (lat == 2) else begin
					other_errors++;
					$display("Ack for %s came %0d cycles after its request", exp_name[0], lat);
				end
				if (exp_rd[0])
					check_value(exp_name[0], exp_val[0], o_wb_data, exp_tol[0]);
				void'(exp_name.pop_front());
				void'(exp_val.pop_front());
				void'(exp_tol.pop_front());
				void'(exp_rd.pop_front());
			end
		end
		if (i_wb_cyc && i_wb_stb)
			req_cyc.push_back(ncyc);
		// Low cyc cancels everything in flight
		if (!i_wb_cyc) begin
			req_cyc.delete();
			exp_name.delete();
			exp_val.delete();
			exp_tol.delete();
			exp_rd.delete();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus driver
	////////////////////////////////////////////////////////////////////////////

	task automatic issue_req(input bit we, input logic [3:0] adr, input logic [31:0] data,
			input logic [3:0] sel, input string name);
		@(posedge i_clk);
		i_wb_cyc  <= 1'b1;
		i_wb_stb  <= 1'b1;
		i_wb_we   <= we;
		i_wb_addr <= adr;
		i_wb_data <= data;
		i_wb_sel  <= sel;
		if (we)
			apply_write(adr, data, sel);
		exp_name.push_back(name);
		exp_val.push_back(we ? 32'h0 : expected_read(adr));
		exp_tol.push_back(we ? 0 : read_tolerance(adr));
		exp_rd.push_back(!we);
	endtask

	// Wait for all acks, then release the bus
	task automatic end_burst();
		int waited;
		waited = 0;
		@(posedge i_clk);
		i_wb_stb <= 1'b0;
		while (exp_val.size() != 0 && waited < 16) begin
			@(posedge i_clk);
			waited++;
		end
		if (exp_val.size() != 0) begin
			other_errors++;
			$display("Timed out waiting for a bus ack");
		end
		i_wb_cyc <= 1'b0;
		i_wb_we  <= 1'b0;
	endtask

	task automatic wait_windows(input int n);
		repeat (n * WIN) @(posedge i_clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		logic [31:0] r_adr;
		logic [31:0] r_dat;
		logic [31:0] r_sel;
		vid_ctrl_pkg::ctl_word_u w;
		pix_reset_sys = 1'b0;
		i_frame_stb   = 1'b0;
		i_wb_cyc      = 1'b0;
		i_wb_stb      = 1'b0;
		i_wb_we       = 1'b0;
		i_wb_addr     = '0;
		i_wb_data     = '0;
		i_wb_sel      = '0;
		stb_mode      = 0;
		stb_div       = 0;
		lfsr          = 16'd37;
		ncyc          = 0;
		n_checks      = 0;
		val_errors    = 0;
		other_errors  = 0;
		sh_ctl.word   = '0;
		sh_ctl.ctl_fields.vid_reset = 1'b1;
		sh_src_sel    = 1'b0;
		for (int k = 0; k < 4; k++) begin
			sh_hm[k] = '0;
			sh_vm[k] = '0;
		end
		@(posedge i_clk);
		pix_reset_sys <= 1'b1;
		repeat (3) @(posedge i_clk);
		pix_reset_sys <= 1'b0;
		repeat (2) @(posedge i_clk);

		// Reset state
		issue_req(1'b0, vid_ctrl_pkg::ADR_CONTROL, '0, 4'hF, "reset_control");
		end_burst();
		@(negedge i_clk);
		check_outputs("reset_outputs");

		// Random writes, each read back
		for (int i = 0; i < 24; i++) begin
			take_bits(3, r_adr);
			take_bits(32, r_dat);
			take_bits(4, r_sel);
			issue_req(1'b1, WR_ADRS[r_adr[2:0]], r_dat, r_sel[3:0], $sformatf("rand_%0d_wr", i));
			end_burst();
			issue_req(1'b0, WR_ADRS[r_adr[2:0]], '0, 4'hF, $sformatf("rand_%0d_rd", i));
			end_burst();
			@(negedge i_clk);
			check_outputs($sformatf("rand_%0d_out", i));
		end

		// Clock frequencies
		wait_windows(3);
		issue_req(1'b0, vid_ctrl_pkg::ADR_SIFREQ, '0, 4'hF, "si_freq");
		end_burst();
		issue_req(1'b0, vid_ctrl_pkg::ADR_PXFREQ, '0, 4'hF, "px_freq");
		end_burst();
		issue_req(1'b0, vid_ctrl_pkg::ADR_HDMIFREQ, '0, 4'hF, "hdmi_freq");
		end_burst();

		// Frame rate with the video path released
		w = sh_ctl;
		w.ctl_fields.vid_reset = 1'b0;
		issue_req(1'b1, vid_ctrl_pkg::ADR_CONTROL, w.word, 4'b0011, "release_wr");
		end_burst();
		stb_mode <= 1;
		wait_windows(2);
		issue_req(1'b0, vid_ctrl_pkg::ADR_FPS, '0, 4'hF, "fps_div12");
		end_burst();
		stb_mode <= 2;
		wait_windows(2);
		issue_req(1'b0, vid_ctrl_pkg::ADR_FPS, '0, 4'hF, "fps_saturated");
		end_burst();

		// Back-to-back burst, then an abandoned request
		issue_req(1'b1, vid_ctrl_pkg::ADR_SIZE, 32'h0123_0456, 4'hF, "b2b_wr");
		issue_req(1'b0, vid_ctrl_pkg::ADR_SIZE, '0, 4'hF, "b2b_size");
		issue_req(1'b0, vid_ctrl_pkg::ADR_CONTROL, '0, 4'hF, "b2b_control");
		issue_req(1'b0, 4'hE, '0, 4'hF, "b2b_unmapped");
		end_burst();
		issue_req(1'b0, vid_ctrl_pkg::ADR_CONTROL, '0, 4'hF, "abandoned");
		@(posedge i_clk);
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
		repeat (6) @(posedge i_clk);
		issue_req(1'b0, vid_ctrl_pkg::ADR_PORCH, '0, 4'hF, "after_abandon");
		end_burst();
		repeat (4) @(posedge i_clk);

		$display("Summary: %0d checks, %0d value errors, %0d other errors, %0d assertion failures",
			n_checks, val_errors, other_errors, dut0.u_vid_regs.u_sva.fail_cnt);
		if (val_errors == 0 && other_errors == 0 && dut0.u_vid_regs.u_sva.fail_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sim/vid_ctrl_sva.sv */
////////////////////////////////////////////////////////////////////////////
// Video register bus checker
// Ack timing and reset values of the register slave
////////////////////////////////////////////////////////////////////////////

module vid_ctrl_sva (
	input logic       i_clk,
	input logic       pix_reset_sys,
	input logic       i_wb_cyc,
	input logic       i_wb_stb,
	input logic       i_wb_ack,
	input logic       i_vid_reset,
	input logic       i_src_sel,
	input logic [1:0] i_pxclk_sel,
	input logic [1:0] i_alpha,
	input logic [2:0] i_cmap_mode
);

	// Failures seen so far
	int fail_cnt = 0;

	// Ack only inside a bus cycle
	ack_in_cycle: assert property (@(posedge i_clk) disable iff (pix_reset_sys)
		i_wb_ack |-> i_wb_cyc)
		else begin
			fail_cnt++;
			$error("Bus ack raised while cyc is low");
		end

	// Two cycles from request to ack while cyc stays high
	ack_latency: assert property (@(posedge i_clk) disable iff (pix_reset_sys)
		(i_wb_cyc && i_wb_stb) ##1 i_wb_cyc |-> ##1 i_wb_ack)
		else begin
			fail_cnt++;
			$error("Bus request not acked two cycles later");
		end

	// Control outputs parked at reset values
	reset_values: assert property (@(posedge i_clk)
		pix_reset_sys |-> (i_vid_reset && !i_src_sel && i_pxclk_sel == 2'b00
			&& i_alpha == 2'b00 && i_cmap_mode == 3'h0 && !i_wb_ack))
		else begin
			fail_cnt++;
			$error("Control outputs left their reset values during reset");
		end

endmodule

bind vid_regs vid_ctrl_sva u_sva (
	.i_clk        (i_clk),
	.pix_reset_sys(pix_reset_sys),
	.i_wb_cyc     (i_wb_cyc),
	.i_wb_stb     (i_wb_stb),
	.i_wb_ack     (o_wb_ack),
	.i_vid_reset  (o_vid_reset),
	.i_src_sel    (o_src_sel),
	.i_pxclk_sel  (o_pxclk_sel),
	.i_alpha      (o_alpha),
	.i_cmap_mode  (o_cmap_mode)
);

/* src/vid_ctrl_top.sv */
////////////////////////////////////////////////////////////////////////////
// Video control top level
// Window pulse, clock and frame rate measurement and the bus registers
////////////////////////////////////////////////////////////////////////////

module vid_ctrl_top #(
	parameter int CLOCKFREQ_HZ = 100_000_000,
	parameter int LGDIM        = 12
) (
	input  logic             i_clk,
	input  logic             pix_reset_sys,
	input  logic             i_si_clk,
	input  logic             i_px_clk,
	input  logic             i_hdmi_clk,
	input  logic             i_frame_stb,
	input  logic             i_wb_cyc,
	input  logic             i_wb_stb,
	input  logic             i_wb_we,
	input  logic [3:0]       i_wb_addr,
	input  logic [31:0]      i_wb_data,
	input  logic [3:0]       i_wb_sel,
	output logic             o_wb_ack,
	output logic [31:0]      o_wb_data,
	output logic [1:0]       o_pxclk_sel,
	output logic             o_src_sel,
	output logic [2:0]       o_cmap_mode,
	output logic [1:0]       o_alpha,
	output logic             o_vid_reset,
	output logic [LGDIM-1:0] o_hm_width,
	output logic [LGDIM-1:0] o_hm_porch,
	output logic [LGDIM-1:0] o_hm_synch,
	output logic [LGDIM-1:0] o_hm_raw,
	output logic [LGDIM-1:0] o_vm_height,
	output logic [LGDIM-1:0] o_vm_porch,
	output logic [LGDIM-1:0] o_vm_synch,
	output logic [LGDIM-1:0] o_vm_raw
);

	localparam int NT = vid_ctrl_pkg::N_TSTCLK;
	localparam int CW = vid_ctrl_pkg::CNT_W;

	logic                           pps;
	logic [NT-1:0]                  tst_clk;
	logic [NT*CW-1:0]               clk_counts;
	logic [vid_ctrl_pkg::FPS_W-1:0] fps;
	logic                           vid_reset;

	// Index order 0 Si, 1 pixel, 2 HDMI
	assign tst_clk     = {i_hdmi_clk, i_px_clk, i_si_clk};
	assign o_vid_reset = vid_reset;

	pps_gen #(
		.CLOCKFREQ_HZ(CLOCKFREQ_HZ)
	) u_pps_gen (
		.i_clk        (i_clk),
		.pix_reset_sys(pix_reset_sys),
		.o_pps        (pps)
	);

	for (genvar g = 0; g < NT; g++) begin : g_clk_counter
		clk_counter u_clk_counter (
			.i_clk        (i_clk),
			.pix_reset_sys(pix_reset_sys),
			.i_tst_clk    (tst_clk[g]),
			.i_pps        (pps),
			.o_counts     (clk_counts[g*CW +: CW])
		);
	end

	frame_rate u_frame_rate (
		.i_clk        (i_clk),
		.pix_reset_sys(pix_reset_sys),
		.i_vid_reset  (vid_reset),
		.i_frame_stb  (i_frame_stb),
		.i_pps        (pps),
		.o_fps        (fps)
	);

	vid_regs #(
		.LGDIM(LGDIM)
	) u_vid_regs (
		.i_clk        (i_clk),
		.pix_reset_sys(pix_reset_sys),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_addr    (i_wb_addr),
		.i_wb_data    (i_wb_data),
		.i_wb_sel     (i_wb_sel),
		.i_clk_counts (clk_counts),
		.i_fps        (fps),
		.o_wb_ack     (o_wb_ack),
		.o_wb_data    (o_wb_data),
		.o_pxclk_sel  (o_pxclk_sel),
		.o_src_sel    (o_src_sel),
		.o_cmap_mode  (o_cmap_mode),
		.o_alpha      (o_alpha),
		.o_vid_reset  (vid_reset),
		.o_hm_width   (o_hm_width),
		.o_hm_porch   (o_hm_porch),
		.o_hm_synch   (o_hm_synch),
		.o_hm_raw     (o_hm_raw),
		.o_vm_height  (o_vm_height),
		.o_vm_porch   (o_vm_porch),
		.o_vm_synch   (o_vm_synch),
		.o_vm_raw     (o_vm_raw)
	);

endmodule

/* src/vid_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Video control registers
// Bus slave with control and mode registers, read-back of the
// measured values and a fixed two-cycle ack
////////////////////////////////////////////////////////////////////////////

module vid_regs #(
	parameter int LGDIM = 12
) (
	input  logic                                               i_clk,
	input  logic                                               pix_reset_sys,
	input  logic                                               i_wb_cyc,
	input  logic                                               i_wb_stb,
	input  logic                                               i_wb_we,
	input  logic [3:0]                                         i_wb_addr,
	input  logic [31:0]                                        i_wb_data,
	input  logic [3:0]                                         i_wb_sel,
	input  logic [vid_ctrl_pkg::N_TSTCLK*vid_ctrl_pkg::CNT_W-1:0] i_clk_counts,
	input  logic [vid_ctrl_pkg::FPS_W-1:0]                     i_fps,
	output logic                                               o_wb_ack,
	output logic [31:0]                                        o_wb_data,
	output logic [1:0]                                         o_pxclk_sel,
	output logic                                               o_src_sel,
	output logic [2:0]                                         o_cmap_mode,
	output logic [1:0]                                         o_alpha,
	output logic                                               o_vid_reset,
	output logic [LGDIM-1:0]                                   o_hm_width,
	output logic [LGDIM-1:0]                                   o_hm_porch,
	output logic [LGDIM-1:0]                                   o_hm_synch,
	output logic [LGDIM-1:0]                                   o_hm_raw,
	output logic [LGDIM-1:0]                                   o_vm_height,
	output logic [LGDIM-1:0]                                   o_vm_porch,
	output logic [LGDIM-1:0]                                   o_vm_synch,
	output logic [LGDIM-1:0]                                   o_vm_raw
);

	localparam int CW = vid_ctrl_pkg::CNT_W;

	vid_ctrl_pkg::ctl_word_u wr_word;
	vid_ctrl_pkg::ctl_word_u rd_word;
	logic                    wb_req;
	logic                    pre_ack;
	logic [31:0]             pre_data;
	// Mode registers indexed by the low address bits
	// 0 size, 1 porch, 2 sync, 3 raw
	logic [LGDIM-1:0]        hm_reg [0:3];
	logic [LGDIM-1:0]        vm_reg [0:3];

	assign wb_req       = i_wb_cyc && i_wb_stb;
	assign wr_word.word = i_wb_data;

	////////////////////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			o_pxclk_sel <= 2'b00;
			o_src_sel   <= 1'b0;
			o_cmap_mode <= 3'h0;
			o_alpha     <= 2'b00;
			// Video path starts held in reset
			o_vid_reset <= 1'b1;
		end else if (wb_req && i_wb_we && (i_wb_addr == vid_ctrl_pkg::ADR_CONTROL)) begin
			// Byte 0 clock, source and reset
			if (i_wb_sel[0]) begin
				o_pxclk_sel <= wr_word.ctl_fields.pxclk_sel;
				o_src_sel   <= wr_word.ctl_fields.src_req
					&& wr_word.ctl_fields.pxclk_sel[1];
				o_vid_reset <= wr_word.ctl_fields.vid_reset;
			end
			// Byte 1 colour map and alpha
			if (i_wb_sel[1]) begin
				o_cmap_mode <= wr_word.ctl_fields.cmap_mode;
				o_alpha     <= wr_word.ctl_fields.alpha;
			end
		end
	end

	// Each half needs both of its byte selects
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			for (int k = 0; k < 4; k++) begin
				hm_reg[k] <= '0;
				vm_reg[k] <= '0;
			end
		end else if (wb_req && i_wb_we) begin
			case (i_wb_addr)
				vid_ctrl_pkg::ADR_SIZE, vid_ctrl_pkg::ADR_PORCH,
				vid_ctrl_pkg::ADR_SYNC, vid_ctrl_pkg::ADR_RAW: begin
					if (&i_wb_sel[1:0])
						hm_reg[i_wb_addr[1:0]] <= wr_word.mode_pair.horz[LGDIM-1:0];
					if (&i_wb_sel[3:2])
						vm_reg[i_wb_addr[1:0]] <= wr_word.mode_pair.vert[LGDIM-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	assign o_hm_width  = hm_reg[0];
	assign o_hm_porch  = hm_reg[1];
	assign o_hm_synch  = hm_reg[2];
	assign o_hm_raw    = hm_reg[3];
	assign o_vm_height = vm_reg[0];
	assign o_vm_porch  = vm_reg[1];
	assign o_vm_synch  = vm_reg[2];
	assign o_vm_raw    = vm_reg[3];

	////////////////////////////////////////////////////////////////////////////
	// Read-back mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_word.word = '0;
		case (i_wb_addr)
			vid_ctrl_pkg::ADR_CONTROL: begin
				rd_word.ctl_fields.alpha     = o_alpha;
				rd_word.ctl_fields.cmap_mode = o_cmap_mode;
				// Bit 6 reads the resolved source select
				rd_word.ctl_fields.src_req   = o_src_sel;
				rd_word.ctl_fields.pxclk_sel = o_pxclk_sel;
				rd_word.ctl_fields.vid_reset = o_vid_reset;
			end
			vid_ctrl_pkg::ADR_SIFREQ:   rd_word.word = 32'(i_clk_counts[0*CW +: CW]);
			vid_ctrl_pkg::ADR_PXFREQ:   rd_word.word = 32'(i_clk_counts[1*CW +: CW]);
			vid_ctrl_pkg::ADR_HDMIFREQ: rd_word.word = 32'(i_clk_counts[2*CW +: CW]);
			vid_ctrl_pkg::ADR_SIZE, vid_ctrl_pkg::ADR_PORCH,
			vid_ctrl_pkg::ADR_SYNC, vid_ctrl_pkg::ADR_RAW: begin
				rd_word.mode_pair.horz = 16'(hm_reg[i_wb_addr[1:0]]);
				rd_word.mode_pair.vert = 16'(vm_reg[i_wb_addr[1:0]]);
			end
			vid_ctrl_pkg::ADR_FPS: rd_word.word = 32'(i_fps);
			// Unmapped reads as zero
			default: rd_word.word = '0;
		endcase
	end

	// Captured on the request, presented with the ack
	always_ff @(posedge i_clk) begin
		if (wb_req && !i_wb_we)
			pre_data <= rd_word.word;
		if (pre_ack)
			o_wb_data <= pre_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Ack pipeline
	////////////////////////////////////////////////////////////////////////////

	// Dropping cyc abandons everything in flight
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			pre_ack  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else if (!i_wb_cyc) begin
			pre_ack  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else begin
			pre_ack  <= i_wb_stb;
			o_wb_ack <= pre_ack;
		end
	end

endmodule

/* src/frame_rate.sv */
////////////////////////////////////////////////////////////////////////////
// Frame rate counter
// Frame strobes per measurement window, saturating at the top
////////////////////////////////////////////////////////////////////////////

module frame_rate (
	input  logic                           i_clk,
	input  logic                           pix_reset_sys,
	input  logic                           i_vid_reset,
	input  logic                           i_frame_stb,
	input  logic                           i_pps,
	output logic [vid_ctrl_pkg::FPS_W-1:0] o_fps
);

	localparam int FW = vid_ctrl_pkg::FPS_W;

	// One extra bit flags saturation
	logic [FW:0] frame_cnt;

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			frame_cnt <= '0;
			o_fps     <= '0;
		end else if (i_vid_reset) begin
			// Held while the video path is in reset
			frame_cnt <= '0;
			o_fps     <= '0;
		end else if (i_pps) begin
			// A strobe on the window edge opens the next window
			frame_cnt <= {{FW{1'b0}}, i_frame_stb};
			if (frame_cnt[FW])
				o_fps <= '1;
			else
				o_fps <= frame_cnt[FW-1:0];
		end else if (i_frame_stb && !frame_cnt[FW]) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

endmodule

/* src/clk_counter.sv */
////////////////////////////////////////////////////////////////////////////
// Test clock counter
// Counts test clock edges in Gray code, brings the count into the
// system domain and reports the edges seen in each window
////////////////////////////////////////////////////////////////////////////

module clk_counter (
	input  logic                           i_clk,
	input  logic                           pix_reset_sys,
	input  logic                           i_tst_clk,
	input  logic                           i_pps,
	output logic [vid_ctrl_pkg::CNT_W-1:0] o_counts
);

	localparam int CW = vid_ctrl_pkg::CNT_W;

	// Test clock domain
	logic [CW-1:0] tst_bin;
	logic [CW-1:0] tst_next;
	logic [CW-1:0] tst_gray;
	// System clock domain
	logic [CW-1:0] sync_q1;
	logic [CW-1:0] sync_q2;
	logic [CW-1:0] sys_bin;
	logic [CW-1:0] snap;

	// Gray back to binary, MSB first
	function automatic logic [CW-1:0] gray2bin(input logic [CW-1:0] g);
		logic [CW-1:0] b;
		b[CW-1] = g[CW-1];
		for (int i = CW - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Edge counter on the test clock
	////////////////////////////////////////////////////////////////////////////

	assign tst_next = tst_bin + 1'b1;

	// Only the Gray register crosses, one bit changes per edge
	always_ff @(posedge i_tst_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			tst_bin  <= '0;
			tst_gray <= '0;
		end else begin
			tst_bin  <= tst_next;
			tst_gray <= tst_next ^ (tst_next >> 1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Synchroniser and window difference
	////////////////////////////////////////////////////////////////////////////

	assign sys_bin = gray2bin(sync_q2);

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			sync_q1  <= '0;
			sync_q2  <= '0;
			snap     <= '0;
			o_counts <= '0;
		end else begin
			sync_q1 <= tst_gray;
			sync_q2 <= sync_q1;
			// Difference wraps cleanly in modulo arithmetic
			if (i_pps) begin
				o_counts <= sys_bin - snap;
				snap     <= sys_bin;
			end
		end
	end

endmodule

/* src/pps_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Measurement window generator
// One-cycle pulse every CLOCKFREQ_HZ system clocks
////////////////////////////////////////////////////////////////////////////

module pps_gen #(
	parameter int CLOCKFREQ_HZ = 100_000_000
) (
	input  logic i_clk,
	input  logic pix_reset_sys,
	output logic o_pps
);

	// Counter wide enough for CLOCKFREQ_HZ-1
	localparam int PW = (CLOCKFREQ_HZ > 1) ? $clog2(CLOCKFREQ_HZ) : 1;

	logic [PW-1:0] pps_cnt;
	logic          pps_wrap;

	assign pps_wrap = (pps_cnt == PW'(CLOCKFREQ_HZ - 1));

	// Free-running, wraps back to zero
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			pps_cnt <= '0;
			o_pps   <= 1'b0;
		end else begin
			if (pps_wrap)
				pps_cnt <= '0;
			else
				pps_cnt <= pps_cnt + 1'b1;
			// Registered wrap marks the window edge
			o_pps <= pps_wrap;
		end
	end

endmodule

/* src/vid_ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Video control package
// Register map of the bus slave, measurement widths and the
// bus write word with its control and mode decodings
////////////////////////////////////////////////////////////////////////////

package vid_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register word addresses
	////////////////////////////////////////////////////////////////////////////

	localparam logic [3:0] ADR_CONTROL  = 4'h0;
	// Measured clock frequencies, edges per window
	localparam logic [3:0] ADR_SIFREQ   = 4'h1;
	localparam logic [3:0] ADR_PXFREQ   = 4'h2;
	localparam logic [3:0] ADR_HDMIFREQ = 4'h3;
	// Commanded output mode, vertical over horizontal
	localparam logic [3:0] ADR_SIZE     = 4'h8;
	localparam logic [3:0] ADR_PORCH    = 4'h9;
	localparam logic [3:0] ADR_SYNC     = 4'hA;
	localparam logic [3:0] ADR_RAW      = 4'hB;
	// Measured incoming frame rate
	localparam logic [3:0] ADR_FPS      = 4'hF;

	// Measured clocks: 0 Si, 1 pixel, 2 HDMI receive
	localparam int N_TSTCLK = 3;
	localparam int CNT_W    = 32;
	localparam int FPS_W    = 8;

	////////////////////////////////////////////////////////////////////////////
	// Bus word decodings
	////////////////////////////////////////////////////////////////////////////

	// Control register layout
	typedef struct packed {
		logic [15:0] rsv_hi;
		logic [1:0]  alpha;
		logic [2:0]  rsv_mid;
		logic [2:0]  cmap_mode;
		logic        rsv_7;
		logic        src_req;
		logic [1:0]  pxclk_sel;
		logic [2:0]  rsv_lo;
		logic        vid_reset;
	} ctl_fields_t;

	// Mode registers hold one vertical and one horizontal value
	typedef struct packed {
		logic [15:0] vert;
		logic [15:0] horz;
	} mode_pair_t;

	typedef union packed {
		logic [31:0] word;
		ctl_fields_t ctl_fields;
		mode_pair_t  mode_pair;
	} ctl_word_u;

endpackage
